// ==== sim.f ====
verilog/clockPkg.sv
verilog/inputDebounce.sv
verilog/panelControl.sv
verilog/timeKeeper.sv
verilog/segmentDisplay.sv
verilog/clockTop.sv
tests/clockTop_chk.sv
tests/clockTop_tb.sv

// ==== Bender.yml ====
package:
  name: clock_panel

sources:
  - files:
      - verilog/clockPkg.sv
      - verilog/inputDebounce.sv
      - verilog/panelControl.sv
      - verilog/timeKeeper.sv
      - verilog/segmentDisplay.sv
      - verilog/clockTop.sv
  - target: test
    files:
      - tests/clockTop_chk.sv
      - tests/clockTop_tb.sv

// ==== tests/clockTop_tb.sv ====
module clockTop_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int Ticks        = 20;
  localparam int Debounce     = 4;
  localparam int PressCycles  = 12;
  localparam int MinuteCycles = clockPkg::SecondsPerMinute * Ticks;
  localparam int ChangeLimit  = MinuteCycles + 4 * Ticks;  // slowest step is one clock minute
  // twice about 140 presses of 24 cycles plus five clock minutes of waiting
  localparam int MaxCycles    = 20000;

  typedef struct packed {
    logic [7:0] hex3;
    logic [7:0] hex2;
    logic [7:0] hex1;
    logic [7:0] hex0;
    logic [9:0] led;
  } panelView;

  typedef struct packed {
    clockPkg::clockMode   mode;
    clockPkg::displayTime shown;
    logic [1:0]           cursor;
    logic                 alarm;
    panelView             observed;
  } checkItem;

  logic       clk;
  logic       reset;
  logic [4:0] switch;
  logic       button2;
  logic       button1;
  logic [7:0] hex3;
  logic [7:0] hex2;
  logic [7:0] hex1;
  logic [7:0] hex0;
  logic [9:0] led;

  panelView             lastView;
  checkItem             checkQueue[$];
  string                testName;
  int                   passCount;
  int                   failCount;
  int                   testFailStart;
  int                   assertFailsSeen;
  int                   cycleCount;
  logic [31:0]          rngState;
  clockPkg::displayTime editModel [2];  // 0 time set, 1 countdown set
  logic [1:0]           cursorModel [2];
  clockPkg::displayTime target;
  int                   hours;
  int                   minutes;

  clockTop #(
    .TicksPerSecond (Ticks),
    .DebounceCycles (Debounce)
  ) UUT (
    .clk     (clk),
    .reset   (reset),
    .switch  (switch),
    .button2 (button2),
    .button1 (button1),
    .hex3    (hex3),
    .hex2    (hex2),
    .hex1    (hex1),
    .hex0    (hex0),
    .led     (led)
  );

  always #4 clk = ~clk;

  // **********************************************************************
  // reference model
  // **********************************************************************

  function automatic logic [7:0] digitPattern(input logic [3:0] d);
    case (d)
      4'd0: return 8'hC0;
      4'd1: return 8'hF9;
      4'd2: return 8'hA4;
      4'd3: return 8'hB0;
      4'd4: return 8'h99;
      4'd5: return 8'h92;
      4'd6: return 8'h82;
      4'd7: return 8'hF8;
      4'd8: return 8'h80;
      4'd9: return 8'h90;
      default: return 8'hFF;
    endcase
  endfunction

  function automatic panelView expectedView(input clockPkg::clockMode mode,
                                            input clockPkg::displayTime shown,
                                            input logic [1:0] cursor, input logic alarm);
    panelView v;
    v = '0;
    case (mode)
      clockPkg::modeSetTime:      v.led = {5'b00001, 5'b01000 >> cursor};
      clockPkg::modeRunClock:     v.led = {5'b00010, 5'b00000};
      clockPkg::modeSetCountdown: v.led = {5'b01000, 5'b01000 >> cursor};
      clockPkg::modeRunCountdown: v.led = {5'b10000, alarm ? 5'b11111 : 5'b00000};
      default: v.led = '0;
    endcase
    if (mode == clockPkg::modeIdle)
    begin
      v.hex3 = 8'hBF;
      v.hex2 = 8'hBF;
      v.hex1 = 8'hBF;
      v.hex0 = 8'hBF;
    end
    else
    begin
      v.hex3 = digitPattern(shown.d3);
      v.hex2 = digitPattern(shown.d2) & 8'h7F;  // separator point on
      v.hex1 = digitPattern(shown.d1);
      v.hex0 = digitPattern(shown.d0);
    end
    return v;
  endfunction

  function automatic clockPkg::displayTime addMinute(input clockPkg::displayTime t);
    int total;
    total = (t.d3 * 10 + t.d2) * 60 + t.d1 * 10 + t.d0 + 1;
    total = total % (24 * 60);
    return {4'(total / 600), 4'((total / 60) % 10), 4'((total % 60) / 10), 4'(total % 10)};
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int nextRandom(input int range);
    rngState = xorshift32(rngState);
    return int'(rngState % range);
  endfunction

  function automatic panelView currentView();
    return {hex3, hex2, hex1, hex0, led};
  endfunction

  // **********************************************************************
  // compare process and timeout
  // **********************************************************************

  always @(negedge clk)
  begin
    checkItem item;
    panelView expected;
    while (checkQueue.size() > 0)
    begin
      item = checkQueue.pop_front();
      expected = expectedView(item.mode, item.shown, item.cursor, item.alarm);
      if (item.observed != expected)
      begin
        $display("Mismatch in %s: expected hex %h led %b, actual hex %h led %b", testName,
                 {expected.hex3, expected.hex2, expected.hex1, expected.hex0}, expected.led,
                 {item.observed.hex3, item.observed.hex2, item.observed.hex1,
                  item.observed.hex0}, item.observed.led);
        failCount++;
      end
      else
        passCount++;
    end
  end

  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount >= MaxCycles)
    begin
      $display("Run timed out after %0d cycles during test %s", cycleCount, testName);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // **********************************************************************
  // stimulus helpers
  // **********************************************************************

  task automatic press(input logic advance);
    if (advance)
      button2 = 1'b0;
    else
      button1 = 1'b0;
    repeat (PressCycles) @(negedge clk);
    button2 = 1'b1;
    button1 = 1'b1;
    repeat (PressCycles) @(negedge clk);
  endtask

  task automatic waitChange();
    panelView now;
    int       waited;
    now = currentView();
    waited = 0;
    while (now == lastView && waited < ChangeLimit)
    begin
      @(negedge clk);
      now = currentView();
      waited++;
    end
    if (now == lastView)
    begin
      $display("Error in %s: display did not change within %0d cycles", testName, ChangeLimit);
      failCount++;
    end
    lastView = now;
  endtask

  task automatic queueCheck(input clockPkg::clockMode mode, input clockPkg::displayTime shown,
                            input logic [1:0] cursor, input logic alarm);
    checkItem item;
    item = '{mode: mode, shown: shown, cursor: cursor, alarm: alarm, observed: lastView};
    checkQueue.push_back(item);
  endtask

  task automatic expectChange(input clockPkg::clockMode mode, input clockPkg::displayTime shown,
                              input logic [1:0] cursor, input logic alarm);
    waitChange();
    queueCheck(mode, shown, cursor, alarm);
  endtask

  task automatic holdSteady(input int cycles);
    panelView now;
    int       i;
    lastView = currentView();
    for (i = 0; i < cycles; i++)
    begin
      @(negedge clk);
      now = currentView();
      if (now != lastView)
      begin
        $display("Mismatch in %s: expected hex %h led %b to hold, actual hex %h led %b",
                 testName, {lastView.hex3, lastView.hex2, lastView.hex1, lastView.hex0},
                 lastView.led, {now.hex3, now.hex2, now.hex1, now.hex0}, now.led);
        failCount++;
        return;
      end
    end
    passCount++;
  endtask

  // walks the cursor over all four digits and steps each one to the target
  task automatic editTo(input int which, input clockPkg::displayTime goal);
    clockPkg::clockMode mode;
    int                 p;
    int                 presses;
    mode = (which == 1) ? clockPkg::modeSetCountdown : clockPkg::modeSetTime;
    for (p = 0; p < clockPkg::DigitCount; p++)
    begin
      while (int'(cursorModel[which]) != p)
      begin
        press(1'b0);
        cursorModel[which] = cursorModel[which] + 2'd1;
        expectChange(mode, editModel[which], cursorModel[which], 1'b0);
      end
      presses = (int'(goal[15-4*p -: 4]) - int'(editModel[which][15-4*p -: 4]) + 10) % 10;
      repeat (presses)
      begin
        press(1'b1);
        editModel[which][15-4*p -: 4] = (editModel[which][15-4*p -: 4] + 4'd1) % 10;
        expectChange(mode, editModel[which], cursorModel[which], 1'b0);
      end
    end
  endtask

  task automatic startTest(input string name);
    testName = name;
    testFailStart = failCount;
  endtask

  task automatic finishTest();
    while (checkQueue.size() != 0)
      @(negedge clk);
    failCount = failCount + UUT.chk.failures - assertFailsSeen;
    assertFailsSeen = UUT.chk.failures;
    $display("test %s finished with %0d errors", testName, failCount - testFailStart);
  endtask

  // **********************************************************************
  // tests
  // **********************************************************************

  initial
  begin
    clk = 1'b0;
    reset = 1'b1;
    switch = 5'b00000;
    button2 = 1'b1;  // buttons idle high
    button1 = 1'b1;
    passCount = 0;
    failCount = 0;
    assertFailsSeen = 0;
    cycleCount = 0;
    testName = "reset";
    rngState = 32'h307;
    editModel[0] = '0;
    editModel[1] = '0;
    cursorModel[0] = 2'd0;
    cursorModel[1] = 2'd0;
    repeat (5) @(negedge clk);
    reset = 1'b0;

    startTest("idle");
    lastView = currentView();
    queueCheck(clockPkg::modeIdle, '0, 2'd0, 1'b0);
    switch = 5'b00100;
    repeat (Debounce + 8) @(negedge clk);  // past the debounce bound
    lastView = currentView();
    queueCheck(clockPkg::modeIdle, '0, 2'd0, 1'b0);
    finishTest();

    startTest("time set");
    switch = 5'b00001;
    expectChange(clockPkg::modeSetTime, editModel[0], cursorModel[0], 1'b0);
    target = {4'(nextRandom(10)), 4'(nextRandom(10)), 4'(nextRandom(10)), 4'(nextRandom(10))};
    editTo(0, target);
    press(1'b0);  // cursor wraps back to d3
    cursorModel[0] = cursorModel[0] + 2'd1;
    expectChange(clockPkg::modeSetTime, editModel[0], cursorModel[0], 1'b0);
    finishTest();

    startTest("midnight wrap");
    editTo(0, 16'h2359);
    switch = 5'b00010;
    expectChange(clockPkg::modeRunClock, 16'h2359, 2'd0, 1'b0);
    expectChange(clockPkg::modeRunClock, 16'h0000, 2'd0, 1'b0);
    finishTest();

    startTest("clock run");
    switch = 5'b00001;
    expectChange(clockPkg::modeSetTime, editModel[0], cursorModel[0], 1'b0);
    hours = nextRandom(24);
    minutes = nextRandom(60);
    target = {4'(hours / 10), 4'(hours % 10), 4'(minutes / 10), 4'(minutes % 10)};
    editTo(0, target);
    switch = 5'b00010;
    expectChange(clockPkg::modeRunClock, target, 2'd0, 1'b0);
    repeat (3)
    begin
      target = addMinute(target);
      expectChange(clockPkg::modeRunClock, target, 2'd0, 1'b0);
    end
    finishTest();

    startTest("countdown alarm");
    switch = 5'b01000;
    expectChange(clockPkg::modeSetCountdown, editModel[1], cursorModel[1], 1'b0);
    editTo(1, 16'h0003);
    switch = 5'b10000;
    expectChange(clockPkg::modeRunCountdown, 16'h0003, 2'd0, 1'b0);
    holdSteady(100);  // not started yet
    press(1'b1);
    expectChange(clockPkg::modeRunCountdown, 16'h0002, 2'd0, 1'b0);
    expectChange(clockPkg::modeRunCountdown, 16'h0001, 2'd0, 1'b0);
    expectChange(clockPkg::modeRunCountdown, 16'h0000, 2'd0, 1'b1);
    finishTest();

    startTest("countdown pause");
    switch = 5'b01000;
    expectChange(clockPkg::modeSetCountdown, editModel[1], cursorModel[1], 1'b0);
    editTo(1, 16'h0100);
    switch = 5'b10000;
    expectChange(clockPkg::modeRunCountdown, 16'h0100, 2'd0, 1'b0);
    press(1'b1);
    expectChange(clockPkg::modeRunCountdown, 16'h0059, 2'd0, 1'b0);
    press(1'b1);  // pause
    holdSteady(100);
    finishTest();

    $display("Checks passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== tests/clockTop_chk.sv ====
module clockTop_chk (
  input logic                 clk,
  input logic                 reset,
  input logic [7:0]           hex3,
  input logic [7:0]           hex2,
  input logic [7:0]           hex1,
  input logic [7:0]           hex0,
  input logic [9:0]           led,
  input clockPkg::panelEvents events
);
  timeunit 1ns;
  timeprecision 1ps;

  int failures = 0;

  // digit codes with the point on or off and the dash
  function automatic logic legalHex(input logic [7:0] h);
    logic [7:0] pointOff;
    pointOff = h | 8'h80;
    return (pointOff inside {8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99,
                             8'h92, 8'h82, 8'hF8, 8'h80, 8'h90}) || (h == 8'hBF);
  endfunction

  hexLegal: assert property (@(posedge clk) disable iff (reset)
    legalHex(hex3) && legalHex(hex2) && legalHex(hex1) && legalHex(hex0))
    else
    begin
      failures++;
      $error("segment output holds a pattern that is neither a digit nor a dash");
    end

  statusLedLegal: assert property (@(posedge clk) disable iff (reset)
    led[4:0] inside {5'b00000, 5'b01000, 5'b00100, 5'b00010, 5'b00001, 5'b11111})
    else
    begin
      failures++;
      $error("led[4:0] is neither a cursor, the alarm nor off");
    end

  tickOneCycle: assert property (@(posedge clk) disable iff (reset)
    events.tick |=> !events.tick)
    else
    begin
      failures++;
      $error("seconds tick lasted two cycles");
    end

  advanceOneCycle: assert property (@(posedge clk) disable iff (reset)
    events.advancePulse |=> !events.advancePulse)
    else
    begin
      failures++;
      $error("advance pulse lasted two cycles");
    end

  cursorOneCycle: assert property (@(posedge clk) disable iff (reset)
    events.cursorPulse |=> !events.cursorPulse)
    else
    begin
      failures++;
      $error("cursor pulse lasted two cycles");
    end

endmodule

bind clockTop clockTop_chk chk (
  .clk    (clk),
  .reset  (reset),
  .hex3   (hex3),
  .hex2   (hex2),
  .hex1   (hex1),
  .hex0   (hex0),
  .led    (led),
  .events (events)
);

// ==== verilog/clockTop.sv ====
module clockTop #(
  parameter int TicksPerSecond = 50000000,
  parameter int DebounceCycles = 65536
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [clockPkg::SwitchWidth-1:0]  switch,
  input  logic                              button2,
  input  logic                              button1,
  output logic [clockPkg::SegmentWidth-1:0] hex3,
  output logic [clockPkg::SegmentWidth-1:0] hex2,
  output logic [clockPkg::SegmentWidth-1:0] hex1,
  output logic [clockPkg::SegmentWidth-1:0] hex0,
  output logic [clockPkg::LedWidth-1:0]     led
);

  clockPkg::panelEvents events;  // producer to buffer and consumer
  clockPkg::keeperState state;

  panelControl #(
    .TicksPerSecond (TicksPerSecond),
    .DebounceCycles (DebounceCycles)
  ) panel (
    .clk     (clk),
    .reset   (reset),
    .switch  (switch),
    .button2 (button2),
    .button1 (button1),
    .events  (events)
  );

  timeKeeper keeper (
    .clk    (clk),
    .reset  (reset),
    .events (events),
    .state  (state)
  );

  segmentDisplay display (
    .clk    (clk),
    .reset  (reset),
    .events (events),
    .state  (state),
    .hex3   (hex3),
    .hex2   (hex2),
    .hex1   (hex1),
    .hex0   (hex0),
    .led    (led)
  );

endmodule

// ==== verilog/segmentDisplay.sv ====
module segmentDisplay (
  input  logic                              clk,
  input  logic                              reset,
  input  clockPkg::panelEvents              events,
  input  clockPkg::keeperState              state,
  output logic [clockPkg::SegmentWidth-1:0] hex3,
  output logic [clockPkg::SegmentWidth-1:0] hex2,
  output logic [clockPkg::SegmentWidth-1:0] hex1,
  output logic [clockPkg::SegmentWidth-1:0] hex0,
  output logic [clockPkg::LedWidth-1:0]     led
);

  clockPkg::displayTime                                  shown;
  clockPkg::bcdDigit [clockPkg::DigitCount-1:0]          digits;
  logic [clockPkg::DigitCount-1:0][clockPkg::SegmentWidth-1:0] codes;
  logic [4:0]                                            modeLeds;
  logic [4:0]                                            statusLeds;
  logic                                                  idle;

  always_comb
  begin
    idle       = 1'b0;
    shown      = '0;
    modeLeds   = 5'b00000;
    statusLeds = 5'b00000;
    case (events.mode)
      clockPkg::modeSetTime:
      begin
        shown      = state.editClock;
        modeLeds   = 5'b00001;
        statusLeds = clockPkg::CursorLeft >> state.clockCursor;
      end
      clockPkg::modeRunClock:
      begin
        shown    = state.clockTime;
        modeLeds = 5'b00010;
      end
      clockPkg::modeSetCountdown:
      begin
        shown      = state.editCountdown;
        modeLeds   = 5'b01000;
        statusLeds = clockPkg::CursorLeft >> state.countdownCursor;
      end
      clockPkg::modeRunCountdown:
      begin
        shown      = state.countdown;
        modeLeds   = 5'b10000;
        statusLeds = state.expired ? clockPkg::AlarmLeds : 5'b00000;
      end
      default: idle = 1'b1;
    endcase
  end

  assign digits = shown;

  always_comb
  begin
    for (int i = 0; i < clockPkg::DigitCount; i++)
      codes[i] = idle ? clockPkg::DashCode : clockPkg::segmentCode(digits[i]);
    if (!idle)
      codes[2][7] = 1'b0;  // HH.MM separator point
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      hex3 <= clockPkg::DashCode;
      hex2 <= clockPkg::DashCode;
      hex1 <= clockPkg::DashCode;
      hex0 <= clockPkg::DashCode;
      led  <= '0;
    end
    else
    begin
      hex3 <= codes[3];
      hex2 <= codes[2];
      hex1 <= codes[1];
      hex0 <= codes[0];
      led  <= {modeLeds, statusLeds};
    end
  end

endmodule

// ==== verilog/timeKeeper.sv ====
module timeKeeper (
  input  logic                 clk,
  input  logic                 reset,
  input  clockPkg::panelEvents events,
  output clockPkg::keeperState state
);

  logic [5:0]           minuteCount;  // ticks within the current minute
  clockPkg::displayTime countdownNext;

  function automatic clockPkg::bcdDigit incDigit(clockPkg::bcdDigit d);
    return (d >= 4'd9) ? 4'd0 : d + 4'd1;
  endfunction

  function automatic clockPkg::displayTime bumpDigit(clockPkg::displayTime t,
                                                     logic [1:0] cursor);
    clockPkg::displayTime r;
    r = t;
    case (cursor)
      2'd0: r.d3 = incDigit(t.d3);
      2'd1: r.d2 = incDigit(t.d2);
      2'd2: r.d1 = incDigit(t.d1);
      default: r.d0 = incDigit(t.d0);
    endcase
    return r;
  endfunction

  // HH:MM plus one minute, 23:59 wraps to 00:00
  function automatic clockPkg::displayTime nextMinute(clockPkg::displayTime t);
    clockPkg::displayTime r;
    r = t;
    if (t.d0 < 4'd9)
      r.d0 = t.d0 + 4'd1;
    else
    begin
      r.d0 = 4'd0;
      if (t.d1 < 4'd5)
        r.d1 = t.d1 + 4'd1;
      else
      begin
        r.d1 = 4'd0;
        if (t.d3 >= 4'd2 && t.d2 >= 4'd3)
          r = '0;  // midnight
        else if (t.d2 >= 4'd9)
        begin
          r.d2 = 4'd0;
          r.d3 = t.d3 + 4'd1;
        end
        else
          r.d2 = t.d2 + 4'd1;
      end
    end
    return r;
  endfunction

  // MM:SS minus one second, caller keeps 00:00 out
  function automatic clockPkg::displayTime prevSecond(clockPkg::displayTime t);
    clockPkg::displayTime r;
    r = t;
    if (t.d0 != 4'd0)
      r.d0 = t.d0 - 4'd1;
    else
    begin
      r.d0 = 4'd9;
      if (t.d1 != 4'd0)
        r.d1 = t.d1 - 4'd1;
      else
      begin
        r.d1 = 4'd5;
        if (t.d2 != 4'd0)
          r.d2 = t.d2 - 4'd1;
        else
        begin
          r.d2 = 4'd9;
          r.d3 = t.d3 - 4'd1;
        end
      end
    end
    return r;
  endfunction

  assign countdownNext = prevSecond(state.countdown);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state       <= '0;
      minuteCount <= '0;
    end
    else
    begin
      case (events.mode)
        clockPkg::modeSetTime:
        begin
          if (events.cursorPulse)
            state.clockCursor <= state.clockCursor + 1'b1;  // wraps mod 4
          if (events.advancePulse)
            state.editClock <= bumpDigit(state.editClock, state.clockCursor);
          state.clockTime <= state.editClock;
          minuteCount     <= '0;
        end
        clockPkg::modeRunClock:
        begin
          if (events.tick)
          begin
            if (minuteCount == clockPkg::SecondsPerMinute - 1)
            begin
              minuteCount     <= '0;
              state.clockTime <= nextMinute(state.clockTime);
            end
            else
              minuteCount <= minuteCount + 1'b1;
          end
        end
        clockPkg::modeSetCountdown:
        begin
          if (events.cursorPulse)
            state.countdownCursor <= state.countdownCursor + 1'b1;
          if (events.advancePulse)
            state.editCountdown <= bumpDigit(state.editCountdown, state.countdownCursor);
          state.countdown <= state.editCountdown;
          state.running   <= 1'b0;
          state.expired   <= 1'b0;
        end
        clockPkg::modeRunCountdown:
        begin
          if (events.advancePulse)
            state.running <= ~state.running;  // start / pause
          if (state.running && events.tick)
          begin
            if (state.countdown == '0)
              state.expired <= 1'b1;
            else
            begin
              state.countdown <= countdownNext;
              if (countdownNext == '0)
                state.expired <= 1'b1;
            end
          end
        end
        default: ;  // idle, everything frozen
      endcase
    end
  end

endmodule

// ==== verilog/panelControl.sv ====
module panelControl #(
  parameter int TicksPerSecond = 50000000,
  parameter int DebounceCycles = 65536
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [clockPkg::SwitchWidth-1:0] switch,
  input  logic                             button2,
  input  logic                             button1,
  output clockPkg::panelEvents             events
);

  logic [clockPkg::SwitchWidth-1:0] switchStable;
  clockPkg::buttonLevels            buttonsRaw;
  clockPkg::buttonLevels            buttonsStable;
  clockPkg::buttonLevels            buttonsPrev;
  clockPkg::clockMode               mode;
  logic                             advancePulse;
  logic                             cursorPulse;
  logic                             tick;
  logic [$clog2(TicksPerSecond)-1:0] tickCount;

  assign buttonsRaw = '{advance: button2, cursor: button1};

  inputDebounce #(
    .payloadType    (logic [clockPkg::SwitchWidth-1:0]),
    .DebounceCycles (DebounceCycles)
  ) switchDebounce (
    .clk    (clk),
    .reset  (reset),
    .raw    (switch),
    .stable (switchStable)
  );

  inputDebounce #(
    .payloadType    (clockPkg::buttonLevels),
    .DebounceCycles (DebounceCycles)
  ) buttonDebounce (
    .clk    (clk),
    .reset  (reset),
    .raw    (buttonsRaw),
    .stable (buttonsStable)
  );

  always_comb
  begin
    case (switchStable)
      5'b00001: mode = clockPkg::modeSetTime;
      5'b00010: mode = clockPkg::modeRunClock;
      5'b01000: mode = clockPkg::modeSetCountdown;
      5'b10000: mode = clockPkg::modeRunCountdown;
      default:  mode = clockPkg::modeIdle;  // 00100 and any value not one-hot
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      buttonsPrev  <= '0;
      advancePulse <= 1'b0;
      cursorPulse  <= 1'b0;
      tickCount    <= '0;
      tick         <= 1'b0;
    end
    else
    begin
      buttonsPrev  <= buttonsStable;
      advancePulse <= buttonsPrev.advance & ~buttonsStable.advance;  // falling edge
      cursorPulse  <= buttonsPrev.cursor & ~buttonsStable.cursor;
      if (tickCount == TicksPerSecond - 1)
      begin
        tickCount <= '0;
        tick      <= 1'b1;
      end
      else
      begin
        tickCount <= tickCount + 1'b1;
        tick      <= 1'b0;
      end
    end
  end

  assign events = '{mode: mode, advancePulse: advancePulse,
                    cursorPulse: cursorPulse, tick: tick};

endmodule

// ==== verilog/inputDebounce.sv ====
module inputDebounce #(
  parameter type payloadType = logic,
  parameter int  DebounceCycles = 4
) (
  input  logic       clk,
  input  logic       reset,
  input  payloadType raw,
  output payloadType stable
);

  payloadType sync1;
  payloadType sync2;
  logic [$clog2(DebounceCycles + 1)-1:0] count;  // cycles sync2 has held

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sync1  <= '0;
      sync2  <= '0;
      count  <= '0;
      stable <= '0;
    end
    else
    begin
      sync1 <= raw;
      sync2 <= sync1;
      if (sync1 != sync2)
        count <= '0;  // still moving
      else if (count != DebounceCycles)
        count <= count + 1'b1;
      else
        stable <= sync2;
    end
  end

endmodule

// ==== verilog/clockPkg.sv ====
package clockPkg;

  // ******************************************************************
  // panel sizes and timing constants
  // ******************************************************************

  localparam int SegmentWidth     = 8;  // active low, bit 7 is the point
  localparam int SwitchWidth      = 5;
  localparam int LedWidth         = 10;
  localparam int DigitCount       = 4;
  localparam int SecondsPerMinute = 60;

  localparam logic [SegmentWidth-1:0] DashCode = 8'hBF;  // middle bar only
  localparam logic [4:0] CursorLeft = 5'b01000;          // cursor 0, shifts right
  localparam logic [4:0] AlarmLeds  = 5'b11111;

  // ******************************************************************
  // types
  // ******************************************************************

  typedef logic [3:0] bcdDigit;

  typedef struct packed {
    bcdDigit d3;  // leftmost
    bcdDigit d2;
    bcdDigit d1;
    bcdDigit d0;
  } displayTime;

  typedef enum logic [2:0] {
    modeSetTime,
    modeRunClock,
    modeSetCountdown,
    modeRunCountdown,
    modeIdle
  } clockMode;

  typedef struct packed {
    logic advance;  // button2, low when pressed
    logic cursor;   // button1, low when pressed
  } buttonLevels;

  typedef struct packed {
    clockMode mode;
    logic     advancePulse;
    logic     cursorPulse;
    logic     tick;
  } panelEvents;

  typedef struct packed {
    displayTime                      clockTime;
    displayTime                      countdown;
    displayTime                      editClock;
    displayTime                      editCountdown;
    logic [$clog2(DigitCount)-1:0]   clockCursor;
    logic [$clog2(DigitCount)-1:0]   countdownCursor;
    logic                            running;
    logic                            expired;
  } keeperState;

  function automatic logic [SegmentWidth-1:0] segmentCode(bcdDigit digit);
    case (digit)
      4'd0: return 8'hC0;
      4'd1: return 8'hF9;
      4'd2: return 8'hA4;
      4'd3: return 8'hB0;
      4'd4: return 8'h99;
      4'd5: return 8'h92;
      4'd6: return 8'h82;
      4'd7: return 8'hF8;
      4'd8: return 8'h80;
      4'd9: return 8'h90;
      default: return DashCode;  // not a decimal digit
    endcase
  endfunction

endpackage
